/* all.f */
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_payload.sv
rtl/rob_status.sv
rtl/rob_ctrl.sv
rtl/rob_commit_stage.sv
rtl/rob_top.sv
test/tb_clock.sv
test/rob_props.sv
test/rob_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module rob_tb -f all.f -o rob_sim
	./obj_dir/rob_sim > sim.log 2>&1; cat sim.log
	@if grep -q ">>> FAIL" sim.log; then exit 1; fi
	@grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/rob_tb.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_tb;
    import rob_pkg::*;

    localparam int NUM_TESTS = 5;
    localparam int LIMIT = 200 * NUM_TESTS + 16;

    typedef struct packed {
        rob_idx_t   idx;
        rob_entry_t entry;
        exc_code_e  code;
    } ref_item_t;

    logic           clk;
    logic           rst;
    dispatch_lane_t dispatch [`ROB_LANES];
    wb_port_t       wb [`ROB_WB_PORTS];
    logic           dis_ready;
    rob_idx_t       dis_idx;
    commit_lane_t   commit [`ROB_LANES];
    exc_report_t    exc;

    logic [31:0] lfsr;
    ref_item_t   ref_q [$];
    ref_item_t   wb_pend [$];
    rob_idx_t    exp_tail;
    rob_idx_t    last_exc_idx;
    exc_code_e   fault_codes [4];
    int          exc_cnt;
    int          errors;
    int          prop_errors;
    int          err_mark;
    int          passes;
    int          fails;

    tb_clock clock_i (.clk(clk));

    rob_top rob_top_i (
        .clk(clk), .rst(rst), .dispatch(dispatch), .wb(wb),
        .dis_ready(dis_ready), .dis_idx(dis_idx), .commit(commit), .exc(exc)
    );

    // the exception report rides with the commit of the faulting entry
    exc_has_commit: assert property (@(posedge clk) disable iff (rst)
        exc.valid |-> commit[0].valid)
        else begin
            $display("Mismatch at time %0t: exc report without a commit lane", $time);
            prop_errors++;
        end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic idle_inputs();
        for (int l = 0; l < `ROB_LANES; l++) begin
            dispatch[l] = '0;
        end
        for (int p = 0; p < `ROB_WB_PORTS; p++) begin
            wb[p] = '0;
        end
    endtask

    // step to the next falling edge and score the commit stage against the queue
    task automatic next_cycle();
        ref_item_t want;
        logic      past_exc;
        @(negedge clk);
        past_exc = 1'b0;
        if (!rst) begin
            for (int i = 0; i < `ROB_LANES; i++) begin
                if (commit[i].valid) begin
                    assert (!past_exc && ref_q.size() > 0)
                        else report_mismatch($sformatf("lane %0d commits a flushed entry", i));
                    if (ref_q.size() > 0) begin
                        want = ref_q.pop_front();
                        want.entry.we = want.entry.we && (want.code == EXC_NONE);
                        assert (commit[i].entry == want.entry)
                            else report_mismatch($sformatf("lane %0d entry %h, expected %h",
                                i, commit[i].entry, want.entry));
                        if (want.code != EXC_NONE) begin
                            assert (exc.valid && exc.rob_idx == want.idx && exc.code == want.code)
                                else report_mismatch($sformatf("exc %h, expected idx %h code %h",
                                    exc, want.idx, want.code));
                            past_exc = 1'b1;
                            last_exc_idx = want.idx;
                            // younger entries are gone after the flush
                            ref_q.delete();
                        end
                    end
                end
            end
            if (exc.valid) begin
                exc_cnt++;
            end
            if (!past_exc) begin
                assert (!exc.valid) else report_mismatch("exc valid with no faulting commit");
            end
        end
    endtask

    task automatic dispatch_batch(input int n, input int exc_pos);
        int        sent;
        int        lanes;
        ref_item_t it;
        sent = 0;
        while (sent < n) begin
            next_cycle();
            idle_inputs();
            if (dis_ready && rand_bits(2) != 0) begin
                lanes = (n - sent >= 2 && rand_bits(1) != 0) ? 2 : 1;
                assert (dis_idx == exp_tail)
                    else report_mismatch($sformatf("dis_idx %h, expected %h", dis_idx, exp_tail));
                for (int l = 0; l < lanes; l++) begin
                    it.idx = rob_idx_t'(exp_tail + 5'(l));
                    it.entry.we = 1'(rand_bits(1));
                    it.entry.vrd = 5'(rand_bits(5));
                    it.entry.prd = `PREG_W'(rand_bits(`PREG_W));
                    it.entry.old_prd = `PREG_W'(rand_bits(`PREG_W));
                    it.code = (sent == exc_pos) ? fault_codes[2'(rand_bits(2))] : EXC_NONE;
                    dispatch[l].valid = 1'b1;
                    dispatch[l].entry = it.entry;
                    ref_q.push_back(it);
                    wb_pend.push_back(it);
                    sent++;
                end
                exp_tail = rob_idx_t'(exp_tail + 5'(lanes));
            end
        end
        next_cycle();
        idle_inputs();
    endtask

    task automatic send_wb(input int port, input int pos);
        wb[port].valid = 1'b1;
        wb[port].rob_idx = wb_pend[pos].idx;
        wb[port].code = wb_pend[pos].code;
        wb_pend.delete(pos);
    endtask

    // random order with zero to all ports busy per cycle
    task automatic writeback_all();
        int k;
        while (wb_pend.size() > 0) begin
            next_cycle();
            idle_inputs();
            k = int'(rand_bits(2)) % (`ROB_WB_PORTS + 1);
            for (int p = 0; p < k && wb_pend.size() > 0; p++) begin
                send_wb(p, int'(rand_bits(4)) % wb_pend.size());
            end
        end
        next_cycle();
        idle_inputs();
    endtask

    task automatic drain();
        while (ref_q.size() != 0) begin
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic finish_test(input string name);
        int total;
        total = errors + prop_errors;
        if (total > err_mark) begin
            fails++;
            $display("test %s: failed with %0d errors", name, total - err_mark);
        end else begin
            passes++;
            $display("test %s: ok", name);
        end
        err_mark = total;
    endtask

    initial begin : watchdog
        repeat (LIMIT) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", LIMIT);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : run
        lfsr = 32'd82543;
        rst = 1'b1;
        idle_inputs();
        fault_codes = '{EXC_ILLEGAL, EXC_LOAD_FAULT, EXC_STORE_FAULT, EXC_ECALL};
        exp_tail = '0;
        exc_cnt = 0;
        errors = 0;
        prop_errors = 0;
        err_mark = 0;
        passes = 0;
        fails = 0;
        repeat (8) next_cycle();
        rst = 1'b0;
        next_cycle();
        assert (!commit[0].valid && !commit[1].valid && !exc.valid && dis_ready && dis_idx == '0)
            else report_mismatch("outputs after reset");
        // 15 entries leave a single free slot
        dispatch_batch(15, -1);
        assert (!dis_ready) else report_mismatch("dis_ready high with one free entry");
        writeback_all();
        drain();
        finish_test("reset and fill");

        for (int r = 0; r < 3; r++) begin
            dispatch_batch(8 + int'(rand_bits(3)), -1);
            writeback_all();
            drain();
        end
        finish_test("in-order retirement");

        dispatch_batch(1, -1);
        send_wb(0, 0);
        next_cycle();
        idle_inputs();
        assert (!commit[0].valid) else report_mismatch("commit one cycle early");
        next_cycle();
        assert (commit[0].valid) else report_mismatch("commit missing after edge N+1");
        drain();
        finish_test("commit latency");

        dispatch_batch(10, 2 + int'(rand_bits(3)));
        writeback_all();
        drain();
        assert (exc_cnt == 1) else report_mismatch($sformatf("%0d exc reports", exc_cnt));
        finish_test("exception");

        while (!dis_ready) begin
            next_cycle();
        end
        exp_tail = rob_idx_t'(last_exc_idx + 5'd1);
        assert (dis_idx == exp_tail)
            else report_mismatch($sformatf("dis_idx %h after flush, expected %h",
                dis_idx, exp_tail));
        dispatch_batch(8, -1);
        writeback_all();
        drain();
        finish_test("recovery after flush");

        $display("tests passed: %0d, failed: %0d", passes, fails);
        if (fails == 0 && errors + prop_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* test/rob_props.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_props (
    input logic                  clk,
    input logic                  rst,
    input logic                  dis_ready,
    input rob_pkg::commit_lane_t commit [`ROB_LANES],
    input rob_pkg::exc_report_t  exc
);

    // commit lanes fill from lane 0 upward
    lane_prefix: assert property (@(posedge clk) disable iff (rst)
        commit[1].valid |-> commit[0].valid)
        else $error("commit lane 1 valid while lane 0 is idle");

    // the flush cycle is the cycle that shows the exception report
    flush_stall: assert property (@(posedge clk) disable iff (rst)
        exc.valid |-> !dis_ready)
        else $error("dis_ready high while an exception is reported");

    flush_quiet: assert property (@(posedge clk) disable iff (rst)
        exc.valid |=> !(commit[0].valid || commit[1].valid))
        else $error("commit valid in the cycle after an exception report");

endmodule

bind rob_top rob_props props_i (
    .clk       (clk),
    .rst       (rst),
    .dis_ready (dis_ready),
    .commit    (commit),
    .exc       (exc)
);

/* test/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
    output logic clk
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

/* rtl/rob_top.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_top (
    input  logic                     clk,
    input  logic                     rst,
    input  rob_pkg::dispatch_lane_t  dispatch [`ROB_LANES],
    input  rob_pkg::wb_port_t        wb [`ROB_WB_PORTS],
    output logic                     dis_ready,
    output rob_pkg::rob_idx_t        dis_idx,
    output rob_pkg::commit_lane_t    commit [`ROB_LANES],
    output rob_pkg::exc_report_t     exc
);

    logic [`ROB_LANES-1:0]  dis_valid;
    rob_pkg::rob_entry_t    dis_entry [`ROB_LANES];
    logic [`ROB_LANES-1:0]  dis_we;
    rob_pkg::rob_idx_t      head;
    logic [`ROB_LANES-1:0]  win_done;
    rob_pkg::exc_code_e     win_code [`ROB_LANES];
    rob_pkg::rob_entry_t    win_entry [`ROB_LANES];
    logic [`ROB_LANES-1:0]  retire_mask;
    logic [`ROB_LANES-1:0]  exc_mask;
    rob_pkg::rob_idx_t      exc_idx;

    generate
        for (genvar i = 0; i < `ROB_LANES; i++) begin : g_dis
            assign dis_valid[i] = dispatch[i].valid;
            assign dis_entry[i] = dispatch[i].entry;
        end
    endgenerate

    rob_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .dis_valid   (dis_valid),
        .win_done    (win_done),
        .win_code    (win_code),
        .dis_ready   (dis_ready),
        .dis_idx     (dis_idx),
        .dis_we      (dis_we),
        .head        (head),
        .retire_mask (retire_mask),
        .exc_mask    (exc_mask),
        .exc_idx     (exc_idx)
    );

    rob_payload u_payload (
        .clk       (clk),
        .rst       (rst),
        .dis_entry (dis_entry),
        .we        (dis_we),
        .tail      (dis_idx),
        .head      (head),
        .win_entry (win_entry)
    );

    rob_status u_status (
        .clk      (clk),
        .rst      (rst),
        .wb       (wb),
        .clr_en   (dis_we),
        .tail     (dis_idx),
        .head     (head),
        .win_done (win_done),
        .win_code (win_code)
    );

    rob_commit_stage u_commit (
        .clk         (clk),
        .rst         (rst),
        .win_entry   (win_entry),
        .retire_mask (retire_mask),
        .exc_mask    (exc_mask),
        .win_code    (win_code),
        .exc_idx     (exc_idx),
        .commit      (commit),
        .exc         (exc)
    );

endmodule

/* rtl/rob_commit_stage.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_commit_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  rob_pkg::rob_entry_t    win_entry [`ROB_LANES],
    input  logic [`ROB_LANES-1:0]  retire_mask,
    input  logic [`ROB_LANES-1:0]  exc_mask,
    input  rob_pkg::exc_code_e     win_code [`ROB_LANES],
    input  rob_pkg::rob_idx_t      exc_idx,
    output rob_pkg::commit_lane_t  commit [`ROB_LANES],
    output rob_pkg::exc_report_t   exc
);
    import rob_pkg::*;

    logic [`ROB_LANES-1:0] commit_vld;
    rob_entry_t            commit_ent [`ROB_LANES];
    logic                  exc_vld;
    rob_idx_t              exc_idx_q;
    exc_code_e             exc_code_q;
    exc_code_e             exc_code_sel;

    always_comb begin
        exc_code_sel = EXC_NONE;
        for (int i = 0; i < `ROB_LANES; i++) begin
            if (exc_mask[i]) begin
                exc_code_sel = win_code[i];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_vld <= '0;
            exc_vld <= 1'b0;
        end else begin
            commit_vld <= retire_mask;
            exc_vld <= |exc_mask;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_LANES; i++) begin
            commit_ent[i] <= win_entry[i];
            // the excepting instruction must not update the rename map
            commit_ent[i].we <= win_entry[i].we & ~exc_mask[i];
        end
        exc_idx_q <= exc_idx;
        exc_code_q <= exc_code_sel;
    end

    always_comb begin
        for (int i = 0; i < `ROB_LANES; i++) begin
            commit[i].valid = commit_vld[i];
            commit[i].entry = commit_ent[i];
        end
        exc.valid = exc_vld;
        exc.rob_idx = exc_idx_q;
        exc.code = exc_code_q;
    end

endmodule

/* rtl/rob_ctrl.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`ROB_LANES-1:0] dis_valid,
    input  logic [`ROB_LANES-1:0] win_done,
    input  rob_pkg::exc_code_e    win_code [`ROB_LANES],
    output logic                  dis_ready,
    output rob_pkg::rob_idx_t     dis_idx,
    output logic [`ROB_LANES-1:0] dis_we,
    output rob_pkg::rob_idx_t     head,
    output logic [`ROB_LANES-1:0] retire_mask,
    output logic [`ROB_LANES-1:0] exc_mask,
    output rob_pkg::rob_idx_t     exc_idx
);
    import rob_pkg::*;

    localparam int CW = $clog2(`ROB_DEPTH) + 1;
    localparam int NW = $clog2(`ROB_LANES) + 1;
    localparam int IW = $bits(rob_idx_t);

    rob_state_e    state;
    rob_idx_t      tail;
    rob_idx_t      head_after_exc;
    logic [CW-1:0] valid_cnt;
    logic [CW-1:0] free_cnt;
    logic [NW-1:0] dis_num;
    logic [NW-1:0] ret_num;
    logic          exc_sel;

    // retire the done prefix of the window up to and including the first excepting lane
    always_comb begin : window_masks
        logic go;
        go = (state == RUN);
        exc_idx = head;
        ret_num = '0;
        for (int i = 0; i < `ROB_LANES; i++) begin
            retire_mask[i] = go && (valid_cnt > CW'(i)) && win_done[i];
            exc_mask[i] = retire_mask[i] && (win_code[i] != EXC_NONE);
            if (exc_mask[i]) begin
                exc_idx = rob_idx_t'(head + IW'(i));
            end
            ret_num = ret_num + NW'(retire_mask[i]);
            go = retire_mask[i] && !exc_mask[i];
        end
    end

    assign exc_sel = |exc_mask;
    assign head_after_exc = rob_idx_t'(exc_idx + IW'(1));
    assign free_cnt = CW'(`ROB_DEPTH) - valid_cnt;

    // dispatch of all lanes or none needs a full group of free slots
    assign dis_ready = (free_cnt >= CW'(`ROB_LANES)) && (state == RUN) && !exc_sel;
    assign dis_we = dis_valid & {`ROB_LANES{dis_ready}};
    assign dis_idx = tail;

    always_comb begin
        dis_num = '0;
        for (int i = 0; i < `ROB_LANES; i++) begin
            dis_num = dis_num + NW'(dis_we[i]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RUN;
            head <= '0;
            tail <= '0;
            valid_cnt <= '0;
        end else if (state == FLUSH) begin
            // drop everything younger than the excepting entry
            state <= RUN;
            tail <= head;
            valid_cnt <= '0;
        end else if (exc_sel) begin
            state <= FLUSH;
            head <= head_after_exc;
        end else begin
            head <= rob_idx_t'(head + IW'(ret_num));
            tail <= rob_idx_t'(tail + IW'(dis_num));
            valid_cnt <= valid_cnt + CW'(dis_num) - CW'(ret_num);
        end
    end

endmodule

/* rtl/rob_status.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_status (
    input  logic                  clk,
    input  logic                  rst,
    input  rob_pkg::wb_port_t     wb [`ROB_WB_PORTS],
    input  logic [`ROB_LANES-1:0] clr_en,
    input  rob_pkg::rob_idx_t     tail,
    input  rob_pkg::rob_idx_t     head,
    output logic [`ROB_LANES-1:0] win_done,
    output rob_pkg::exc_code_e    win_code [`ROB_LANES]
);
    import rob_pkg::*;

    localparam int PW = $clog2(`ROB_DEPTH);

    logic [`ROB_DEPTH-1:0] done;
    exc_code_e             code_mem [`ROB_DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= '0;
        end else begin
            // new entries start not done
            for (int i = 0; i < `ROB_LANES; i++) begin
                if (clr_en[i]) begin
                    done[tail.num + PW'(i)] <= 1'b0;
                end
            end
            for (int p = 0; p < `ROB_WB_PORTS; p++) begin
                if (wb[p].valid) begin
                    done[wb[p].rob_idx.num] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < `ROB_WB_PORTS; p++) begin
            if (wb[p].valid) begin
                code_mem[wb[p].rob_idx.num] <= wb[p].code;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `ROB_LANES; i++) begin
            win_done[i] = done[head.num + PW'(i)];
            win_code[i] = code_mem[head.num + PW'(i)];
        end
    end

endmodule

/* rtl/rob_payload.sv */
`timescale 1ns/100ps
`include "rob_config.svh"

module rob_payload (
    input  logic                clk,
    input  logic                rst,
    input  rob_pkg::rob_entry_t dis_entry [`ROB_LANES],
    input  logic [`ROB_LANES-1:0] we,
    input  rob_pkg::rob_idx_t   tail,
    input  rob_pkg::rob_idx_t   head,
    output rob_pkg::rob_entry_t win_entry [`ROB_LANES]
);
    import rob_pkg::*;

    localparam int BW = $clog2(`ROB_LANES);
    localparam int BD = `ROB_DEPTH / `ROB_LANES;
    localparam int RW = $clog2(BD);
    localparam int PW = $clog2(`ROB_DEPTH);

    logic [`ROB_LANES-1:0] bank_we;
    logic [RW-1:0]         bank_waddr [`ROB_LANES];
    logic [RW-1:0]         bank_raddr [`ROB_LANES];
    rob_entry_t            bank_wdata [`ROB_LANES];
    rob_entry_t            bank_rdata [`ROB_LANES];

    // bank b takes the lane whose slot tail+lane falls into it
    always_comb begin : write_rotate
        logic [BW-1:0] lane;
        logic [PW-1:0] pos;
        for (int b = 0; b < `ROB_LANES; b++) begin
            lane = BW'(b) - tail.num[BW-1:0];
            pos = tail.num + PW'(lane);
            // no writes while the pointers are held in reset
            bank_we[b] = ~rst & we[lane];
            bank_waddr[b] = pos[PW-1:BW];
            bank_wdata[b] = dis_entry[lane];
        end
    end

    always_comb begin : read_rotate
        logic [BW-1:0] lane;
        logic [PW-1:0] pos;
        logic [BW-1:0] bank;
        for (int b = 0; b < `ROB_LANES; b++) begin
            lane = BW'(b) - head.num[BW-1:0];
            pos = head.num + PW'(lane);
            bank_raddr[b] = pos[PW-1:BW];
        end
        // and back again from banks to commit lanes
        for (int l = 0; l < `ROB_LANES; l++) begin
            bank = head.num[BW-1:0] + BW'(l);
            win_entry[l] = bank_rdata[bank];
        end
    end

    generate
        for (genvar b = 0; b < `ROB_LANES; b++) begin : g_bank
            rob_entry_t mem [BD];

            always_ff @(posedge clk) begin
                if (bank_we[b]) begin
                    mem[bank_waddr[b]] <= bank_wdata[b];
                end
            end

            assign bank_rdata[b] = mem[bank_raddr[b]];
        end
    endgenerate

endmodule

/* rtl/rob_pkg.sv */
`include "rob_config.svh"

package rob_pkg;

    typedef enum logic [`EXC_W-1:0] {
        EXC_ILLEGAL     = 2,
        EXC_LOAD_FAULT  = 5,
        EXC_STORE_FAULT = 7,
        EXC_ECALL       = 11,
        EXC_NONE        = '1
    } exc_code_e;

    typedef enum logic {
        RUN,
        FLUSH
    } rob_state_e;

    // wrap bit on top tells a full ROB from an empty one
    typedef struct packed {
        logic                             wrap;
        logic [$clog2(`ROB_DEPTH)-1:0]    num;
    } rob_idx_t;

    typedef struct packed {
        logic                we;
        logic [4:0]          vrd;
        logic [`PREG_W-1:0]  prd;
        logic [`PREG_W-1:0]  old_prd;
    } rob_entry_t;

    typedef struct packed {
        logic       valid;
        rob_entry_t entry;
    } dispatch_lane_t;

    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        exc_code_e code;
    } wb_port_t;

    // entry.we is already cleared for an excepting instruction
    typedef struct packed {
        logic       valid;
        rob_entry_t entry;
    } commit_lane_t;

    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        exc_code_e code;
    } exc_report_t;

endpackage

/* rtl/rob_config.svh */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// number of ROB entries as a power of two
`define ROB_DEPTH 16

// dispatch width, commit width and payload bank count
`define ROB_LANES 2

// physical register number width
`define PREG_W 6

// exception code width where all ones means no exception
`define EXC_W 4

// writeback ports into the status array
`define ROB_WB_PORTS 2

`endif
